/* branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
  input  spu_odd_pkg::odd_op_e op,
  input  spu_odd_pkg::qword_t  rt,
  input  logic [0:15]          imm16,
  input  spu_odd_pkg::pc_t     pc,
  output spu_odd_pkg::pc_t     new_pc,
  output spu_odd_pkg::qword_t  link
);

  import spu_odd_pkg::*;

  // fall-through pc
  pc_t  pc_next;
  // relative target, wraps at 10 bits
  pc_t  target;
  // brnz condition on preferred word
  logic rt_nz;

  assign pc_next = pc + 10'd1;
  // low 10 bits of imm16 are enough after truncation
  assign target  = pc + imm16[6:15];
  assign rt_nz   = |rt[0:31];

  always_comb begin
    case (op)
      br, brsl: new_pc = target;
      brnz:     new_pc = rt_nz ? target : pc_next;
      default:  new_pc = pc_next;
    endcase
  end

  // return address sits in the preferred word
  // other words zero
  always_comb begin
    if (op == brsl) begin
      link = {22'd0, pc_next, 96'd0};
    end else begin
      link = '0;
    end
  end

endmodule

/* ls_unit.sv */
`timescale 1ns/1ns

module ls_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  spu_odd_pkg::odd_op_e  op,
  input  spu_odd_pkg::qword_t   ra,
  input  spu_odd_pkg::qword_t   rt,
  input  logic [0:9]            imm10,
  input  logic [0:15]           imm16,
  input  logic                  preload_en,
  input  spu_odd_pkg::ls_addr_t preload_addr,
  input  spu_odd_pkg::qword_t   preload_data,
  output spu_odd_pkg::qword_t   load_data
);

  import spu_odd_pkg::*;

  // d-form sum, ra word 0 plus scaled imm10
  logic [0:31] d_sum;
  ls_addr_t    d_addr;
  ls_addr_t    a_addr;
  // selected aligned address
  ls_addr_t    addr;
  logic        st_en;
  qword_t      mem [ls_depth];

  assign d_sum  = ra[0:31] + {18'd0, imm10, 4'b0000};
  // keep 15 bits, drop byte offset
  assign d_addr = {d_sum[17:27], 4'b0000};
  // imm16 << 2, 15 bits, aligned
  assign a_addr = {imm16[3:13], 4'b0000};

  always_comb begin
    case (op)
      lqd, stqd: addr = d_addr;
      default:   addr = a_addr;
    endcase
  end

  // no stores while held in reset
  assign st_en = !rst && (op == stqd || op == stqa);

  // preload wins over a store in the same cycle
  always_ff @(posedge clk) begin
    if (preload_en && !rst) begin
      mem[preload_addr[0:10]] <= preload_data;
    end else if (st_en) begin
      mem[addr[0:10]] <= rt;
    end
  end

  // quadword index is the upper 11 address bits
  assign load_data = mem[addr[0:10]];

endmodule

/* odd_pipe.f */
spu_odd_pkg.sv
perm_unit.sv
branch_unit.sv
ls_unit.sv
odd_result_pipe.sv
odd_pipe.sv
tb_clock_gen.sv
odd_pipe_tb.sv

/* odd_pipe.sv */
`timescale 1ns/1ns

module odd_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  spu_odd_pkg::odd_op_e     op,
  input  spu_odd_pkg::reg_addr_t   dst,
  input  spu_odd_pkg::qword_t      ra,
  input  spu_odd_pkg::qword_t      rb,
  // rt data for stores and branches
  input  spu_odd_pkg::qword_t      rc,
  input  logic [0:6]               imm7,
  input  logic [0:9]               imm10,
  input  logic [0:15]              imm16,
  input  spu_odd_pkg::pc_t         pc,
  input  logic                     preload_en,
  input  spu_odd_pkg::ls_addr_t    preload_addr,
  input  spu_odd_pkg::qword_t      preload_data,
  output spu_odd_pkg::pc_t         new_pc,
  output spu_odd_pkg::fwd_stages_t fwd,
  output spu_odd_pkg::reg_addr_t   wb_addr,
  output spu_odd_pkg::qword_t      wb_data,
  output logic                     wb_en
);

  import spu_odd_pkg::*;

  // unit results into the result pipe
  qword_t perm_result;
  qword_t link;
  qword_t load_data;

  perm_unit perm_i (
    .op     (op),
    .ra     (ra),
    .rb     (rb),
    .imm7   (imm7),
    .result (perm_result)
  );

  branch_unit branch_i (
    .op     (op),
    .rt     (rc),
    .imm16  (imm16),
    .pc     (pc),
    .new_pc (new_pc),
    .link   (link)
  );

  ls_unit ls_i (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .ra           (ra),
    .rt           (rc),
    .imm10        (imm10),
    .imm16        (imm16),
    .preload_en   (preload_en),
    .preload_addr (preload_addr),
    .preload_data (preload_data),
    .load_data    (load_data)
  );

  odd_result_pipe result_i (
    .clk         (clk),
    .rst         (rst),
    .op          (op),
    .dst         (dst),
    .perm_result (perm_result),
    .load_data   (load_data),
    .link        (link),
    .fwd         (fwd),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .wb_en       (wb_en)
  );

endmodule

/* odd_pipe_tb.sv */
`timescale 1ns/1ns

module odd_pipe_tb;

  import spu_odd_pkg::*;

  localparam int clk_period     = 40;
  localparam int preload_count  = 64;
  localparam int load_count     = 64;
  localparam int instr_count    = 400;
  localparam int drain_cycles   = 10;
  localparam int timeout_cycles = 16 + 64 + 400 + 20;

  logic        clk;
  logic        rst;
  odd_op_e     op;
  reg_addr_t   dst;
  qword_t      ra;
  qword_t      rb;
  qword_t      rc;
  logic [0:6]  imm7;
  logic [0:9]  imm10;
  logic [0:15] imm16;
  pc_t         pc;
  logic        preload_en;
  ls_addr_t    preload_addr;
  qword_t      preload_data;
  pc_t         new_pc;
  fwd_stages_t fwd;
  reg_addr_t   wb_addr;
  qword_t      wb_data;
  logic        wb_en;

  // lcg state
  logic [31:0] seed = 32'h9cc0_0bd2;
  // mirror of local store
  qword_t      shadow [ls_depth];
  // expectations of the instruction now on the inputs
  fwd_pkt_t    cur_pkt;
  pc_t         exp_pc;
  // model of stages 2 to 7 and write-back
  fwd_pkt_t    hist [2:7];
  logic        exp_wb_en = 1'b0;
  reg_addr_t   exp_wb_addr;
  qword_t      exp_wb_data;
  int          errors = 0;
  int          checks = 0;

  tb_clock_gen clock_i (
    .clk (clk),
    .rst (rst)
  );

  odd_pipe dut_i (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .dst          (dst),
    .ra           (ra),
    .rb           (rb),
    .rc           (rc),
    .imm7         (imm7),
    .imm10        (imm10),
    .imm16        (imm16),
    .pc           (pc),
    .preload_en   (preload_en),
    .preload_addr (preload_addr),
    .preload_data (preload_data),
    .new_pc       (new_pc),
    .fwd          (fwd),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .wb_en        (wb_en)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic qword_t rand_qword();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // byte 0 is the leftmost byte, bytes move toward it
  function automatic qword_t permute_qword(odd_op_e o, qword_t a, qword_t b, logic [0:6] i7);
    int     n;
    qword_t q;
    n = (o == rotqby) ? int'(b[28:31]) : int'(i7[2:6]);
    for (int i = 0; i < 16; i++) begin
      if (o != shlqbyi) begin
        q[8*i +: 8] = a[8*((i + n) % 16) +: 8];
      end else if (i + n < 16) begin
        q[8*i +: 8] = a[8*(i + n) +: 8];
      end else begin
        q[8*i +: 8] = 8'h00;
      end
    end
    return q;
  endfunction

  function automatic pc_t branch_pc(odd_op_e o, qword_t rt, logic [0:15] i16, pc_t p);
    logic [31:0] fall;
    logic [31:0] target;
    fall   = (32'(p) + 32'd1) & 32'h3ff;
    target = (32'(p) + 32'(i16)) & 32'h3ff;
    case (o)
      br, brsl: return 10'(target);
      brnz:     return (rt[0:31] != 32'd0) ? 10'(target) : 10'(fall);
      default:  return 10'(fall);
    endcase
  endfunction

  // return address in the preferred word only
  function automatic qword_t link_qword(odd_op_e o, pc_t p);
    qword_t q;
    q = '0;
    if (o == brsl) q[0:31] = (32'(p) + 32'd1) & 32'h3ff;
    return q;
  endfunction

  // quadword index, 15-bit byte address with low nibble cleared
  function automatic int ls_index(odd_op_e o, logic [31:0] ra_w0, logic [0:9] i10,
                                  logic [0:15] i16);
    logic [31:0] a;
    if (o == lqd || o == stqd) a = ra_w0 + (32'(i10) << 4);
    else a = 32'(i16) << 2;
    return int'((a & 32'h7ff0) >> 4);
  endfunction

  // stores and nop leave an empty packet
  function automatic fwd_pkt_t expected_packet(odd_op_e o, reg_addr_t d, qword_t perm,
                                               qword_t load, qword_t lnk);
    fwd_pkt_t p;
    p = '0;
    case (o)
      shlqbyi, rotqbyi, rotqby: p.unit = 3'd5;
      lqd, lqa:                 p.unit = 3'd6;
      br, brnz, brsl:           p.unit = 3'd7;
      default:                  p.unit = 3'd0;
    endcase
    if (p.unit != 3'd0) begin
      p.result  = (p.unit == 3'd5) ? perm : (p.unit == 3'd6) ? load : lnk;
      p.dst     = d;
      p.latency = 4'd7;
      p.reg_wr  = (o != br) && (o != brnz);
    end
    return p;
  endfunction

  task automatic check_value(input string name, input logic [159:0] expected,
                             input logic [159:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s at %0t: expected %h, actual %h", name, $time, expected, actual);
    end
  endtask

  // random fields, local-store ops aimed at quadword idx
  task automatic issue(input odd_op_e o, input int idx);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    int          ls_idx;
    r1 = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    op    = o;
    dst   = r1[31:25];
    imm7  = r1[24:18];
    pc    = r1[17:8];
    imm10 = r2[31:22];
    imm16 = r2[21:6];
    ra    = rand_qword();
    rb    = rand_qword();
    rc    = rand_qword();
    // rotqby count, any of 0 to 15
    rb[28:31] = r3[30:27];
    // brnz not taken half the time
    if (r3[31]) rc[0:31] = 32'd0;
    preload_en = 1'b0;
    case (o)
      lqd, stqd: begin
        // upper ra bits random, truncated away
        ra[0:31] = (ra[0:31] & 32'hffff_800f) | (32'(idx / 2) << 4);
        imm10    = 10'(idx - idx / 2);
      end
      lqa, stqa: imm16 = (imm16 & 16'he003) | 16'(idx << 2);
      default: ;
    endcase
    ls_idx  = ls_index(o, ra[0:31], imm10, imm16);
    exp_pc  = branch_pc(o, rc, imm16, pc);
    cur_pkt = expected_packet(o, dst, permute_qword(o, ra, rb, imm7), shadow[ls_idx],
                              link_qword(o, pc));
    if (o == stqd || o == stqa) shadow[ls_idx] = rc;
  endtask

  // new_pc before each edge, registered outputs at the falling edge
  initial begin
    for (int k = 2; k <= 7; k++) hist[k] = '0;
    @(negedge rst);
    forever begin
      @(posedge clk);
      check_value("new_pc", 160'(exp_pc), 160'(new_pc));
      exp_wb_en   = hist[7].reg_wr;
      exp_wb_addr = hist[7].dst;
      exp_wb_data = hist[7].result;
      for (int k = 7; k > 2; k--) hist[k] = hist[k-1];
      hist[2] = cur_pkt;
      @(negedge clk);
      for (int k = 2; k <= 7; k++) begin
        check_value($sformatf("fwd[%0d]", k), 160'(hist[k]), 160'(fwd[k]));
      end
      check_value("wb_en", 160'(exp_wb_en), 160'(wb_en));
      if (exp_wb_en) begin
        check_value("wb_addr", 160'(exp_wb_addr), 160'(wb_addr));
        check_value("wb_data", 160'(exp_wb_data), 160'(wb_data));
      end
    end
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("run timed out after %0d cycles without finishing", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    logic [31:0] r;
    preload_addr = '0;
    preload_data = '0;
    issue(nop, 0);
    @(negedge rst);
    // empty pipe straight out of reset
    check_value("wb_en", 160'(0), 160'(wb_en));
    for (int k = 2; k <= 7; k++) begin
      check_value($sformatf("fwd[%0d]", k), 160'(0), 160'(fwd[k]));
    end
    for (int i = 0; i < preload_count; i++) begin
      @(negedge clk);
      issue(nop, 0);
      preload_en   = 1'b1;
      preload_addr = 15'(i << 4);
      preload_data = rand_qword();
      shadow[i]    = preload_data;
    end
    // one lqa per preloaded quadword
    for (int i = 0; i < load_count; i++) begin
      @(negedge clk);
      issue(lqa, i);
    end
    // mixed stream over all opcodes
    for (int i = load_count; i < instr_count; i++) begin
      @(negedge clk);
      r = next_rand();
      issue(odd_op_e'(r[30:24] % 7'd11), int'(r[21:16]));
    end
    // let the last results reach write-back
    repeat (drain_cycles) begin
      @(negedge clk);
      issue(nop, 0);
    end
    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* odd_result_pipe.sv */
`timescale 1ns/1ns

module odd_result_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  spu_odd_pkg::odd_op_e     op,
  input  spu_odd_pkg::reg_addr_t   dst,
  input  spu_odd_pkg::qword_t      perm_result,
  input  spu_odd_pkg::qword_t      load_data,
  input  spu_odd_pkg::qword_t      link,
  output spu_odd_pkg::fwd_stages_t fwd,
  output spu_odd_pkg::reg_addr_t   wb_addr,
  output spu_odd_pkg::qword_t      wb_data,
  output logic                     wb_en
);

  import spu_odd_pkg::*;

  odd_unit_t unit;
  qword_t    result;
  // combinational stage 1
  fwd_pkt_t  stage1;

  // result mux by unit
  always_comb begin
    unit = odd_op_unit(op);
    case (unit)
      unit_perm:   result = perm_result;
      unit_load:   result = load_data;
      unit_branch: result = link;
      default:     result = '0;
    endcase
  end

  // nop and stores leave an empty slot
  always_comb begin
    if (unit == unit_none) begin
      stage1 = '0;
    end else begin
      stage1.unit    = unit;
      stage1.result  = result;
      stage1.dst     = dst;
      stage1.latency = odd_latency;
      stage1.reg_wr  = odd_op_writes(op);
    end
  end

  // one stage per edge, never stalls
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fwd   <= '0;
      wb_en <= 1'b0;
    end else begin
      fwd[2] <= stage1;
      for (int k = 3; k <= 7; k++) begin
        fwd[k] <= fwd[k-1];
      end
      wb_en <= fwd[7].reg_wr;
    end
  end

  // write-back payload, qualified by wb_en
  always_ff @(posedge clk) begin
    wb_addr <= fwd[7].dst;
    wb_data <= fwd[7].result;
  end

endmodule

/* perm_unit.sv */
`timescale 1ns/1ns

module perm_unit (
  input  spu_odd_pkg::odd_op_e op,
  input  spu_odd_pkg::qword_t  ra,
  input  spu_odd_pkg::qword_t  rb,
  input  logic [0:6]           imm7,
  output spu_odd_pkg::qword_t  result
);

  import spu_odd_pkg::*;

  // byte count, 5 bits so shlqbyi can reach 31
  logic [0:4]   byte_cnt;
  // same count in bits
  logic [0:7]   bit_cnt;
  // ra doubled up, upper half gives the rotate
  logic [0:255] ra_dbl;

  // count select
  always_comb begin
    case (op)
      // rb word 0, low nibble only
      rotqby:  byte_cnt = {1'b0, rb[28:31]};
      // rotate is modulo 16
      rotqbyi: byte_cnt = {1'b0, imm7[3:6]};
      // low 5 bits of imm7
      default: byte_cnt = imm7[2:6];
    endcase
  end

  assign bit_cnt = {byte_cnt, 3'b000};

  // bytes move toward byte 0
  assign ra_dbl = {ra, ra} << bit_cnt;

  always_comb begin
    case (op)
      // 16 or more bytes clears everything
      shlqbyi:         result = ra << bit_cnt;
      rotqbyi, rotqby: result = ra_dbl[0:127];
      default:         result = '0;
    endcase
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the odd pipe testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --timescale 1ns/1ns --top-module odd_pipe_tb \
    -f odd_pipe.f -o odd_pipe_sim &&
  ./obj_dir/odd_pipe_sim | tee /dev/stderr | grep -q '^\*\* PASS \*\*$' &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* spu_odd_pkg.sv */
package spu_odd_pkg;

  // byte 0 is the most significant byte, bit 0 the msb
  typedef logic [0:127] qword_t;
  typedef logic [0:6]   reg_addr_t;
  // word-granular pc
  typedef logic [0:9]   pc_t;
  // byte address into local store
  typedef logic [0:14]  ls_addr_t;
  typedef logic [0:2]   odd_unit_t;

  // unit ids carried in the packet, 0 means empty slot
  localparam odd_unit_t unit_none   = 3'd0;
  localparam odd_unit_t unit_perm   = 3'd5;
  localparam odd_unit_t unit_load   = 3'd6;
  localparam odd_unit_t unit_branch = 3'd7;

  // local store is 32 KiB of quadwords
  localparam int ls_depth = 2048;
  // every odd-pipe result takes seven stages
  localparam logic [0:3] odd_latency = 4'd7;

  typedef enum logic [0:6] {
    nop,
    shlqbyi,
    rotqbyi,
    rotqby,
    br,
    brnz,
    brsl,
    lqd,
    lqa,
    stqd,
    stqa
  } odd_op_e;

  // forwarding packet, 143 bits
  typedef struct packed {
    odd_unit_t  unit;
    qword_t     result;
    reg_addr_t  dst;
    logic [0:3] latency;
    logic       reg_wr;
  } fwd_pkt_t;

  // stages 2 to 7, visible to the forwarding unit
  typedef fwd_pkt_t [2:7] fwd_stages_t;

  // stores and nop occupy no result slot
  function automatic odd_unit_t odd_op_unit(odd_op_e op);
    case (op)
      shlqbyi, rotqbyi, rotqby: odd_op_unit = unit_perm;
      lqd, lqa:                 odd_op_unit = unit_load;
      br, brnz, brsl:           odd_op_unit = unit_branch;
      default:                  odd_op_unit = unit_none;
    endcase
  endfunction

  // ops that write a register
  function automatic logic odd_op_writes(odd_op_e op);
    case (op)
      shlqbyi, rotqbyi, rotqby, lqd, lqa, brsl: odd_op_writes = 1'b1;
      default:                                  odd_op_writes = 1'b0;
    endcase
  endfunction

endpackage

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 40 ns period
  localparam int half_period  = 20;
  localparam int reset_cycles = 16;

  initial clk = 1'b0;
  always #half_period clk = ~clk;

  // release on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule
